// File: include/pipe_defs.svh
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// ------------------------------------------------------------
// data path widths
// ------------------------------------------------------------
`define WORD_W          32      // host pipe word
`define ADDR_W          30      // memory byte address
`define COUNT_W         11      // fifo count, holds 0..1024

// ------------------------------------------------------------
// host block throttle
// ------------------------------------------------------------
`define BLOCK_SIZE      128     // 512 byte host block
`define FIFO_DEPTH      1024    // words stored per pipe fifo
`define FIFO_SIZE       1023    // size the throttle works against
`define BUFFER_HEADROOM 20      // slack for count update latency

// ------------------------------------------------------------
// memory side
// ------------------------------------------------------------
`define BURST_LEN       32      // words per memory burst
`define MEM_WORDS       4096    // on-chip memory, 16 KB

`endif

// File: source/host_pkg.sv
`include "pipe_defs.svh"

package host_pkg;

	typedef logic [`WORD_W-1:0]  word_t;        // one pipe word
	typedef logic [`COUNT_W-1:0] fifo_count_t;  // fifo occupancy

	// control wire from the host
	typedef struct packed {
		logic               reads_en;    // memory to pipe out
		logic               writes_en;   // pipe in to memory
		logic [`ADDR_W-1:0] start_addr;  // byte address, taken when an enable rises
	} dma_ctrl_t;

	// fifo flags seen by the host
	typedef struct packed {
		logic in_full;
		logic in_empty;
		logic out_full;
		logic out_empty;
	} pipe_status_t;

endpackage

// File: source/mem_pkg.sv
`include "pipe_defs.svh"

package mem_pkg;

	typedef logic [`ADDR_W-1:0] byte_addr_t;  // memory byte address
	typedef logic [5:0]         burst_len_t;  // burst length minus one

	// instruction codes as on the memory controller command port
	typedef enum logic [2:0] {
		MEM_WRITE = 3'b000,
		MEM_READ  = 3'b001
	} mem_instr_e;

	typedef struct packed {
		mem_instr_e instr;
		byte_addr_t byte_addr;
		burst_len_t bl;
	} mem_cmd_t;

	typedef enum logic [2:0] {
		IDLE,       // pick a direction
		FILL,       // pop inbound words into the write path
		WRITE_CMD,  // commit the filled burst
		READ_CMD,   // request a burst from memory
		DRAIN       // push returned words outbound
	} dma_state_e;

endpackage

// File: source/pipe_fifo.sv
`timescale 1ns/1ps

module pipe_fifo #(
	parameter int DEPTH = 1024
) (
	input  logic                  okClk,
	input  logic                  i_reset,
	input  logic                  i_push,
	input  host_pkg::word_t       i_data,
	input  logic                  i_pop,
	output host_pkg::word_t       o_data,
	output host_pkg::fifo_count_t o_count,
	output logic                  o_full,
	output logic                  o_empty
);
	import host_pkg::*;

	localparam int PTR_W = $clog2(DEPTH);

	word_t            mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	fifo_count_t      count;
	logic             push_ok;
	logic             pop_ok;

	assign o_full  = (count == fifo_count_t'(DEPTH));
	assign o_empty = (count == '0);
	assign push_ok = i_push && !o_full;
	assign pop_ok  = i_pop && !o_empty;
	assign o_data  = mem[rd_ptr];       // head word falls through
	assign o_count = count;

	always_ff @(posedge okClk) begin
		if (push_ok) begin
			mem[wr_ptr] <= i_data;
		end
	end

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;    // wraps, depth is a power of two
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + fifo_count_t'(push_ok) - fifo_count_t'(pop_ok);
		end
	end

	// the reader and the writer both sit in other modules
	a_no_pop_empty: assert property (@(posedge okClk) disable iff (i_reset)
		i_pop |-> !o_empty)
		else $error("pipe_fifo: pop while empty");

	a_no_push_full: assert property (@(posedge okClk) disable iff (i_reset)
		i_push |-> !o_full)
		else $error("pipe_fifo: push while full");

endmodule

// File: source/host_pipe_bridge.sv
`timescale 1ns/1ps
`include "pipe_defs.svh"

module host_pipe_bridge (
	input  logic                   okClk,
	input  logic                   i_reset,
	input  logic                   i_pipe_in_write,
	input  host_pkg::word_t        i_pipe_in_data,
	output logic                   o_pipe_in_ready,
	input  logic                   i_pipe_out_read,
	output host_pkg::word_t        o_pipe_out_data,
	output logic                   o_pipe_out_ready,
	input  logic                   i_in_pop,
	output host_pkg::word_t        o_in_word,
	output host_pkg::fifo_count_t  o_in_count,
	input  logic                   i_out_push,
	input  host_pkg::word_t        i_out_word,
	output host_pkg::fifo_count_t  o_out_count,
	output host_pkg::pipe_status_t o_status
);
	import host_pkg::*;

	// a full block must still fit after the count catches up
	localparam int IN_READY_MAX = `FIFO_SIZE - `BUFFER_HEADROOM - `BLOCK_SIZE;

	fifo_count_t in_count;
	fifo_count_t out_count;
	logic        in_full;
	logic        in_empty;
	logic        out_full;
	logic        out_empty;

	pipe_fifo #(.DEPTH(`FIFO_DEPTH)) u_in_fifo (
		.okClk   (okClk),
		.i_reset (i_reset),
		.i_push  (i_pipe_in_write),   // host pipe in
		.i_data  (i_pipe_in_data),
		.i_pop   (i_in_pop),          // dma side
		.o_data  (o_in_word),
		.o_count (in_count),
		.o_full  (in_full),
		.o_empty (in_empty)
	);

	pipe_fifo #(.DEPTH(`FIFO_DEPTH)) u_out_fifo (
		.okClk   (okClk),
		.i_reset (i_reset),
		.i_push  (i_out_push),        // dma side
		.i_data  (i_out_word),
		.i_pop   (i_pipe_out_read),   // host pipe out
		.o_data  (o_pipe_out_data),
		.o_count (out_count),
		.o_full  (out_full),
		.o_empty (out_empty)
	);

	assign o_in_count  = in_count;
	assign o_out_count = out_count;

	// ------------------------------------------------------------
	// block throttle and status, one cycle behind the counts
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (i_reset) begin
			o_pipe_in_ready    <= 1'b1;
			o_pipe_out_ready   <= 1'b0;
			o_status.in_full   <= 1'b0;
			o_status.in_empty  <= 1'b1;
			o_status.out_full  <= 1'b0;
			o_status.out_empty <= 1'b1;
		end else begin
			o_pipe_in_ready    <= (in_count <= fifo_count_t'(IN_READY_MAX));
			o_pipe_out_ready   <= (out_count >= fifo_count_t'(`BLOCK_SIZE));  // whole block waiting
			o_status.in_full   <= in_full;
			o_status.in_empty  <= in_empty;
			o_status.out_full  <= out_full;
			o_status.out_empty <= out_empty;
		end
	end

	// the host only starts blocks on ready, so the headroom must cover it
	a_host_no_overrun: assert property (@(posedge okClk) disable iff (i_reset)
		in_full |-> !i_pipe_in_write)
		else $error("host_pipe_bridge: host write into full inbound fifo");

endmodule

// File: source/block_dma.sv
`timescale 1ns/1ps
`include "pipe_defs.svh"

module block_dma (
	input  logic                  okClk,
	input  logic                  i_reset,
	input  host_pkg::dma_ctrl_t   i_ctrl,
	input  host_pkg::word_t       i_in_word,
	input  host_pkg::fifo_count_t i_in_count,
	output logic                  o_in_pop,
	output logic                  o_out_push,
	output host_pkg::word_t       o_out_word,
	input  host_pkg::fifo_count_t i_out_count,
	output logic                  o_cmd_en,
	output mem_pkg::mem_cmd_t     o_cmd,
	input  logic                  i_busy,
	output logic                  o_wr_en,
	output host_pkg::word_t       o_wr_data,
	input  logic                  i_rd_valid,
	input  host_pkg::word_t       i_rd_data
);
	import host_pkg::*;
	import mem_pkg::*;

	localparam int         CNT_W       = $clog2(`BURST_LEN);
	localparam byte_addr_t BURST_BYTES = byte_addr_t'(`BURST_LEN * (`WORD_W / 8));
	localparam burst_len_t BURST_BL    = burst_len_t'(`BURST_LEN - 1);

	dma_state_e       state;
	logic [CNT_W-1:0] word_cnt;
	logic             last_word;
	byte_addr_t       wr_ptr;
	byte_addr_t       rd_ptr;
	logic             writes_en_q;
	logic             reads_en_q;
	fifo_count_t      out_space;
	logic             wr_go;
	logic             rd_go;

	assign last_word = (word_cnt == CNT_W'(`BURST_LEN - 1));
	assign out_space = fifo_count_t'(`FIFO_DEPTH) - i_out_count;
	assign wr_go     = i_ctrl.writes_en && (i_in_count >= fifo_count_t'(`BURST_LEN));
	assign rd_go     = i_ctrl.reads_en
		&& (out_space >= fifo_count_t'(`BURST_LEN + `BUFFER_HEADROOM));

	// inbound head goes straight onto the write data path
	assign o_in_pop   = (state == FILL);
	assign o_wr_en    = (state == FILL);
	assign o_wr_data  = i_in_word;
	assign o_out_push = (state == DRAIN) && i_rd_valid;
	assign o_out_word = i_rd_data;

	// ------------------------------------------------------------
	// burst state machine
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (i_reset) begin
			state       <= IDLE;
			word_cnt    <= '0;
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			writes_en_q <= 1'b0;
			reads_en_q  <= 1'b0;
			o_cmd_en    <= 1'b0;
		end else begin
			writes_en_q <= i_ctrl.writes_en;
			reads_en_q  <= i_ctrl.reads_en;
			o_cmd_en    <= 1'b0;
			case (state)
				IDLE: begin
					word_cnt <= '0;
					if (wr_go) begin            // writes win over reads
						state <= FILL;
					end else if (rd_go) begin
						state <= READ_CMD;
					end
				end
				FILL: begin
					word_cnt <= word_cnt + 1'b1;
					if (last_word) begin
						state <= WRITE_CMD;
					end
				end
				WRITE_CMD: begin
					if (!i_busy) begin
						o_cmd_en <= 1'b1;
						wr_ptr   <= wr_ptr + BURST_BYTES;
						state    <= IDLE;
					end
				end
				READ_CMD: begin
					if (!i_busy) begin
						o_cmd_en <= 1'b1;
						rd_ptr   <= rd_ptr + BURST_BYTES;
						state    <= DRAIN;
					end
				end
				DRAIN: begin
					if (i_rd_valid) begin
						word_cnt <= word_cnt + 1'b1;
						if (last_word) begin
							state <= IDLE;
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
			// a rising enable restarts its own pointer
			if (i_ctrl.writes_en && !writes_en_q) begin
				wr_ptr <= i_ctrl.start_addr;
			end
			if (i_ctrl.reads_en && !reads_en_q) begin
				rd_ptr <= i_ctrl.start_addr;
			end
		end
	end

	// command payload, qualified by o_cmd_en
	always_ff @(posedge okClk) begin
		if (state == WRITE_CMD) begin
			o_cmd <= '{instr: MEM_WRITE, byte_addr: wr_ptr, bl: BURST_BL};
		end else if (state == READ_CMD) begin
			o_cmd <= '{instr: MEM_READ, byte_addr: rd_ptr, bl: BURST_BL};
		end
	end

	// the command is registered, so this relies on the port only going busy after a command
	a_cmd_not_busy: assert property (@(posedge okClk) disable iff (i_reset)
		o_cmd_en |-> !i_busy)
		else $error("block_dma: command issued while memory port busy");

endmodule

// File: source/mem_port.sv
`timescale 1ns/1ps
`include "pipe_defs.svh"

module mem_port (
	input  logic              okClk,
	input  logic              i_reset,
	input  logic              i_cmd_en,
	input  mem_pkg::mem_cmd_t i_cmd,
	output logic              o_busy,
	input  logic              i_wr_en,
	input  host_pkg::word_t   i_wr_data,
	output logic              o_rd_valid,
	output host_pkg::word_t   o_rd_data
);
	import host_pkg::*;
	import mem_pkg::*;

	localparam int MEM_AW = $clog2(`MEM_WORDS);
	localparam int BUF_W  = $clog2(`BURST_LEN);

	word_t             ram [`MEM_WORDS];
	word_t             wr_buf [`BURST_LEN];
	logic [BUF_W:0]    wr_cnt;      // words waiting for a write command
	logic              commit_q;
	logic              rd_wait;
	logic              rd_run;
	logic [MEM_AW-1:0] rd_addr;
	burst_len_t        rd_left;     // words still to return, minus one
	logic [MEM_AW-1:0] cmd_addr;
	logic              wr_cmd;
	logic              rd_cmd;

	assign cmd_addr   = i_cmd.byte_addr[2 +: MEM_AW];  // word address, wraps around
	assign wr_cmd     = i_cmd_en && !o_busy && (i_cmd.instr == MEM_WRITE);
	assign rd_cmd     = i_cmd_en && !o_busy && (i_cmd.instr == MEM_READ);
	assign o_busy     = commit_q || rd_wait || rd_run;
	assign o_rd_valid = rd_run;
	assign o_rd_data  = ram[rd_addr];

	// ------------------------------------------------------------
	// write buffer and burst commit
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (i_wr_en) begin
			wr_buf[wr_cnt[BUF_W-1:0]] <= i_wr_data;
		end
		if (wr_cmd) begin
			for (int i = 0; i < `BURST_LEN; i++) begin
				if (i <= int'(i_cmd.bl)) begin
					ram[cmd_addr + MEM_AW'(i)] <= wr_buf[i];
				end
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (i_reset) begin
			wr_cnt   <= '0;
			commit_q <= 1'b0;
			rd_wait  <= 1'b0;
			rd_run   <= 1'b0;
		end else begin
			commit_q <= wr_cmd;             // one busy cycle per commit
			if (wr_cmd) begin
				wr_cnt <= '0;
			end else if (i_wr_en) begin
				wr_cnt <= wr_cnt + 1'b1;
			end
			rd_wait <= rd_cmd;              // first word two cycles after the command
			if (rd_wait) begin
				rd_run <= 1'b1;
			end else if (rd_run && (rd_left == '0)) begin
				rd_run <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// read sequencer
	// ------------------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rd_cmd) begin
			rd_addr <= cmd_addr;
			rd_left <= i_cmd.bl;
		end else if (rd_run) begin
			rd_addr <= rd_addr + 1'b1;
			rd_left <= rd_left - 1'b1;
		end
	end

	// the data path and the command come from separate cycles of the dma
	a_burst_matches_data: assert property (@(posedge okClk) disable iff (i_reset)
		(i_cmd_en && (i_cmd.instr == MEM_WRITE)) |-> (int'(wr_cnt) == int'(i_cmd.bl) + 1))
		else $error("mem_port: write burst length differs from words written");

endmodule

// File: source/pipe_top.sv
`timescale 1ns/1ps

module pipe_top (
	input  logic                   okClk,
	input  logic                   i_reset,
	input  logic                   i_pipe_in_write,
	input  host_pkg::word_t        i_pipe_in_data,
	output logic                   o_pipe_in_ready,
	input  logic                   i_pipe_out_read,
	output host_pkg::word_t        o_pipe_out_data,
	output logic                   o_pipe_out_ready,
	input  host_pkg::dma_ctrl_t    i_ctrl,
	output host_pkg::pipe_status_t o_status
);
	import host_pkg::*;
	import mem_pkg::*;

	// bridge to dma
	logic        in_pop;
	word_t       in_word;
	fifo_count_t in_count;
	logic        out_push;
	word_t       out_word;
	fifo_count_t out_count;

	// dma to memory port
	logic        cmd_en;
	mem_cmd_t    cmd;
	logic        busy;
	logic        wr_en;
	word_t       wr_data;
	logic        rd_valid;
	word_t       rd_data;

	host_pipe_bridge u_bridge (
		.okClk            (okClk),
		.i_reset          (i_reset),
		.i_pipe_in_write  (i_pipe_in_write),
		.i_pipe_in_data   (i_pipe_in_data),
		.o_pipe_in_ready  (o_pipe_in_ready),
		.i_pipe_out_read  (i_pipe_out_read),
		.o_pipe_out_data  (o_pipe_out_data),
		.o_pipe_out_ready (o_pipe_out_ready),
		.i_in_pop         (in_pop),
		.o_in_word        (in_word),
		.o_in_count       (in_count),
		.i_out_push       (out_push),
		.i_out_word       (out_word),
		.o_out_count      (out_count),
		.o_status         (o_status)
	);

	block_dma u_dma (
		.okClk       (okClk),
		.i_reset     (i_reset),
		.i_ctrl      (i_ctrl),
		.i_in_word   (in_word),
		.i_in_count  (in_count),
		.o_in_pop    (in_pop),
		.o_out_push  (out_push),
		.o_out_word  (out_word),
		.i_out_count (out_count),
		.o_cmd_en    (cmd_en),
		.o_cmd       (cmd),
		.i_busy      (busy),
		.o_wr_en     (wr_en),
		.o_wr_data   (wr_data),
		.i_rd_valid  (rd_valid),
		.i_rd_data   (rd_data)
	);

	mem_port u_mem (
		.okClk      (okClk),
		.i_reset    (i_reset),
		.i_cmd_en   (cmd_en),
		.i_cmd      (cmd),
		.o_busy     (busy),
		.i_wr_en    (wr_en),
		.i_wr_data  (wr_data),
		.o_rd_valid (rd_valid),
		.o_rd_data  (rd_data)
	);

endmodule

// File: testbench/tb_pipe_top.sv
`timescale 1ns/1ps
`include "pipe_defs.svh"

module tb_pipe_top;
	import host_pkg::*;

	localparam int TIMEOUT        = 5000;   // cycles per wait
	localparam int QUIET_CYCLES   = 64;     // longer than one read burst in flight
	localparam int FLAG_IN_READY  = 0;
	localparam int FLAG_OUT_READY = 1;
	localparam int FLAG_IN_EMPTY  = 2;
	localparam int REC_TEST [5]   = '{2, 3, 3, 4, 5};

	logic         okClk;
	logic         i_reset;
	logic         i_pipe_in_write;
	word_t        i_pipe_in_data;
	logic         o_pipe_in_ready;
	logic         i_pipe_out_read;
	word_t        o_pipe_out_data;
	logic         o_pipe_out_ready;
	dma_ctrl_t    i_ctrl;
	pipe_status_t o_status;

	logic [31:0] rec [0:19];   // test, start address, blocks, base
	integer      seed;
	int          test_errors;
	int          total_errors;
	int          tests_run;
	int          tests_failed;
	int          cycles;

	pipe_top DUT (.*);

	initial begin
		okClk = 1'b0;
		forever #4 okClk = ~okClk;
	end

	// ------------------------------------------------------------
	// checks and waits
	// ------------------------------------------------------------
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("** Error: %s = %h, expected %h at %0t", name, got, expected, $time);
			test_errors++;
		end
	endtask

	task automatic stop_on_timeout(input string what);
		$display("timeout after %0d cycles waiting for %s", TIMEOUT, what);
		$display("Testbench failed");
		$finish;
	endtask

	function automatic logic flag_value(input int sel);
		case (sel)
			FLAG_IN_READY:  return o_pipe_in_ready;
			FLAG_OUT_READY: return o_pipe_out_ready;
			default:        return o_status.in_empty;
		endcase
	endfunction

	// outputs are read right after the edge, before the dut updates
	task automatic wait_flag(input int sel, input logic level, input string what,
		output int waited);
		waited = 0;
		@(posedge okClk);
		while (flag_value(sel) !== level) begin
			if (waited == TIMEOUT) begin
				stop_on_timeout(what);
			end
			@(posedge okClk);
			waited++;
		end
	endtask

	function automatic logic [31:0] record_field(input int r, input int f);
		return rec[4 * r + f];
	endfunction

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %s, %0d mismatches", num, name,
			(test_errors == 0) ? "ok" : "FAILED", test_errors);
		tests_run++;
		if (test_errors != 0) begin
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	// ------------------------------------------------------------
	// host pipe driver and reader
	// ------------------------------------------------------------
	task automatic drive_ctrl(input logic rd, input logic wr, input logic [31:0] addr);
		i_ctrl <= '{reads_en: rd, writes_en: wr, start_addr: addr[`ADDR_W-1:0]};
	endtask

	task automatic set_ctrl(input logic rd, input logic wr, input logic [31:0] addr);
		drive_ctrl(rd, wr, addr);
		repeat (2) @(posedge okClk);   // dma sees the level and its edge
	endtask

	task automatic write_block(input word_t base);
		int waited;
		wait_flag(FLAG_IN_READY, 1'b1, "o_pipe_in_ready high", waited);
		for (int i = 0; i < `BLOCK_SIZE; i++) begin
			i_pipe_in_write <= 1'b1;
			i_pipe_in_data  <= base + i;
			@(posedge okClk);
		end
		i_pipe_in_write <= 1'b0;
		@(posedge okClk);              // ready catches up with the last write
	endtask

	task automatic read_block(input word_t base, input logic gaps);
		int waited;
		int gap;
		wait_flag(FLAG_OUT_READY, 1'b1, "o_pipe_out_ready high", waited);
		for (int i = 0; i < `BLOCK_SIZE; i++) begin
			gap = gaps ? ({$random(seed)} % 4) : 0;
			repeat (gap) begin
				i_pipe_out_read <= 1'b0;
				@(posedge okClk);
				check_value("o_status.out_full", 32'(o_status.out_full), 32'd0);
			end
			i_pipe_out_read <= 1'b1;
			@(posedge okClk);          // head word is popped on this edge
			check_value("o_pipe_out_data", o_pipe_out_data, base + i);
			check_value("o_status.out_full", 32'(o_status.out_full), 32'd0);
		end
		i_pipe_out_read <= 1'b0;
		@(posedge okClk);
	endtask

	// pops leftover read-ahead words until the fifo stays empty
	task automatic flush_outbound();
		int quiet;
		int n;
		quiet = 0;
		n = 0;
		while (quiet < QUIET_CYCLES) begin
			if (n == TIMEOUT) begin
				stop_on_timeout("outbound FIFO to stay empty");
			end
			@(posedge okClk);
			n++;
			if (!o_status.out_empty) begin
				quiet = 0;
				i_pipe_out_read <= 1'b1;
				@(posedge okClk);
				i_pipe_out_read <= 1'b0;
				@(posedge okClk);      // status is one cycle behind the count
			end else begin
				quiet++;
			end
		end
	endtask

	task automatic write_record(input int r);
		int waited;
		set_ctrl(1'b0, 1'b1, record_field(r, 1));
		for (int b = 0; b < int'(record_field(r, 2)); b++) begin
			write_block(record_field(r, 3) + b * `BLOCK_SIZE);
		end
		wait_flag(FLAG_IN_EMPTY, 1'b1, "inbound FIFO to drain", waited);
		set_ctrl(1'b0, 1'b0, record_field(r, 1));
	endtask

	task automatic read_record(input int r, input logic gaps);
		set_ctrl(1'b1, 1'b0, record_field(r, 1));
		for (int b = 0; b < int'(record_field(r, 2)); b++) begin
			read_block(record_field(r, 3) + b * `BLOCK_SIZE, gaps);
		end
		set_ctrl(1'b0, 1'b0, record_field(r, 1));
		flush_outbound();
	endtask

	// ------------------------------------------------------------
	// test sequence
	// ------------------------------------------------------------
	initial begin
		seed            = 26184;
		test_errors     = 0;
		total_errors    = 0;
		tests_run       = 0;
		tests_failed    = 0;
		i_reset         = 1'b1;
		i_pipe_in_write = 1'b0;
		i_pipe_in_data  = '0;
		i_pipe_out_read = 1'b0;
		i_ctrl          = '0;
		$readmemh("testbench/pipe_input.txt", rec);
		repeat (3) @(posedge okClk);
		i_reset <= 1'b0;
		@(posedge okClk);

		for (int r = 0; r < 5; r++) begin
			if (record_field(r, 0) !== REC_TEST[r]) begin
				$display("data file record %0d names test %h, expected test %0d",
					r + 1, record_field(r, 0), REC_TEST[r]);
				test_errors++;
			end
		end
		@(posedge okClk);
		check_value("o_pipe_in_ready", 32'(o_pipe_in_ready), 32'd1);
		check_value("o_pipe_out_ready", 32'(o_pipe_out_ready), 32'd0);
		check_value("o_status.in_full", 32'(o_status.in_full), 32'd0);
		check_value("o_status.in_empty", 32'(o_status.in_empty), 32'd1);
		check_value("o_status.out_full", 32'(o_status.out_full), 32'd0);
		check_value("o_status.out_empty", 32'(o_status.out_empty), 32'd1);
		end_test(1, "reset state");

		write_record(0);
		read_record(0, 1'b0);
		end_test(2, "loopback");

		write_record(1);
		write_record(2);
		read_record(2, 1'b0);                // later record first
		read_record(1, 1'b0);
		end_test(3, "addressing");

		set_ctrl(1'b0, 1'b0, record_field(3, 1));
		for (int b = 0; b < int'(record_field(3, 2)); b++) begin
			write_block(record_field(3, 3) + b * `BLOCK_SIZE);
		end
		wait_flag(FLAG_IN_READY, 1'b0, "o_pipe_in_ready low above 875 words", cycles);
		set_ctrl(1'b0, 1'b1, record_field(3, 1));
		wait_flag(FLAG_IN_READY, 1'b1, "o_pipe_in_ready back high", cycles);
		wait_flag(FLAG_IN_EMPTY, 1'b1, "inbound FIFO to drain", cycles);
		set_ctrl(1'b0, 1'b0, record_field(3, 1));
		end_test(4, "inbound throttle");

		write_record(4);
		@(posedge okClk);
		check_value("o_pipe_out_ready", 32'(o_pipe_out_ready), 32'd0);
		check_value("o_status.out_empty", 32'(o_status.out_empty), 32'd1);
		drive_ctrl(1'b1, 1'b0, record_field(4, 1));
		wait_flag(FLAG_OUT_READY, 1'b1, "first outbound block", cycles);
		// at most one word arrives per cycle
		if (cycles + 1 < `BLOCK_SIZE) begin
			$display("o_pipe_out_ready rose after %0d cycles, before a full block fits",
				cycles + 1);
			test_errors++;
		end
		for (int b = 0; b < int'(record_field(4, 2)); b++) begin
			read_block(record_field(4, 3) + b * `BLOCK_SIZE, 1'b1);
		end
		set_ctrl(1'b0, 1'b0, record_field(4, 1));
		flush_outbound();
		end_test(5, "outbound throttle");

		$display("tests %0d, failed %0d, mismatches %0d", tests_run, tests_failed,
			total_errors);
		if (tests_failed == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: testbench/pipe_input.txt
// columns: test number, start byte address, block count, base data value
// all fields hex, word i of a record is base + i
00000002 00000000 00000002 10000000
00000003 00000800 00000001 20000000
00000003 00001000 00000002 30000000
00000004 00002000 00000007 40000000
00000005 00003000 00000002 50000000

// File: tb.f
+incdir+include
source/host_pkg.sv
source/mem_pkg.sv
source/pipe_fifo.sv
source/host_pipe_bridge.sv
source/block_dma.sv
source/mem_port.sv
source/pipe_top.sv
testbench/tb_pipe_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f tb.f --top-module tb_pipe_top -o tb_pipe_top

./obj_dir/tb_pipe_top | tee sim.log

grep -q "Testbench passed" sim.log
